//--- verilog/tlk_reg_pkg.sv
// register map, widths and interrupt word layout shared by the TLK2711 register block
package tlk_reg_pkg;

    localparam int REG_DATA_W  = 64;
    localparam int HOST_ADDR_W = 16;
    localparam int REG_OFS_W   = 8;
    localparam int DMA_ADDR_W  = 32;

    // host address window
    localparam logic [HOST_ADDR_W-1:0] ADDR_MASK = 16'h00FF;
    localparam logic [HOST_ADDR_W-1:0] ADDR_BASE = 16'h0000;

    ////////////////////////////////////////
    // register offsets inside the window
    ////////////////////////////////////////
    localparam logic [REG_OFS_W-1:0] TX_CFG_OFS    = 8'h08;
    localparam logic [REG_OFS_W-1:0] RX_CFG_OFS    = 8'h10;
    localparam logic [REG_OFS_W-1:0] TX_ADDR_OFS   = 8'h20;
    localparam logic [REG_OFS_W-1:0] TX_LENGTH_OFS = 8'h28;
    localparam logic [REG_OFS_W-1:0] TX_PACKET_OFS = 8'h30;
    localparam logic [REG_OFS_W-1:0] TX_STATUS_OFS = 8'h38;
    localparam logic [REG_OFS_W-1:0] RX_ADDR_OFS   = 8'h40;
    localparam logic [REG_OFS_W-1:0] RX_CTRL_OFS   = 8'h48;
    localparam logic [REG_OFS_W-1:0] RX_STATUS_OFS = 8'h50;
    localparam logic [REG_OFS_W-1:0] IRQ_OFS       = 8'h60;
    localparam logic [REG_OFS_W-1:0] SOFT_RST_OFS  = 8'h70;

    // tags in the top nibble of status reads
    localparam logic [3:0] TX_STATUS_TAG = 4'h9;
    localparam logic [3:0] RX_STATUS_TAG = 4'hA;

    // interrupt kind codes
    localparam logic [3:0] IRQ_KIND_TX   = 4'd1;
    localparam logic [3:0] IRQ_KIND_RX   = 4'd2;
    localparam logic [3:0] IRQ_KIND_LOSS = 4'd3;

    localparam logic [15:0] TX_DONE_MARK = 16'h5AA5;

    localparam int SOFT_RST_CYCLES = 256;

    ////////////////////////////////////////
    // interrupt report word, kind on top
    ////////////////////////////////////////
    typedef struct packed {
        logic [3:0]  kind;
        logic [17:0] pad;
        logic [7:0]  data_type;
        logic        file_end;
        logic        checksum;
        logic [15:0] frame_num;
        logic [15:0] frame_len;
    } irq_rx_view_t;

    typedef struct packed {
        logic [3:0]  kind;
        logic [43:0] pad;
        logic [15:0] done_mark;
    } irq_tx_view_t;

    typedef struct packed {
        logic [3:0]  kind;
        logic [51:0] pad;
        logic [5:0]  rx_status;
        logic        sync_loss;
        logic        link_loss;
    } irq_loss_view_t;

    typedef union packed {
        irq_rx_view_t   rx;
        irq_tx_view_t   tx;
        irq_loss_view_t loss;
    } irq_word_u;

endpackage

//--- verilog/reg_bus_if.sv
// decoded register access strobes from the host port to the register logic
interface reg_bus_if;
    import tlk_reg_pkg::*;

    // one-cycle strobes, no back-pressure
    logic                  wen;
    logic [REG_OFS_W-1:0]  wofs;
    logic [REG_DATA_W-1:0] wdata;
    logic                  ren;
    logic [REG_OFS_W-1:0]  rofs;

    modport host (
        output wen,
        output wofs,
        output wdata,
        output ren,
        output rofs
    );

    modport target (
        input wen,
        input wofs,
        input wdata,
        input ren,
        input rofs
    );

endinterface

//--- verilog/reg_host_port.sv
// host access input stage, two register stages with the address window check
module reg_host_port (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_reg_wen,
    input  logic [tlk_reg_pkg::HOST_ADDR_W-1:0] i_reg_waddr,
    input  logic [tlk_reg_pkg::REG_DATA_W-1:0]  i_reg_wdata,
    input  logic                                i_reg_ren,
    input  logic [tlk_reg_pkg::HOST_ADDR_W-1:0] i_reg_raddr,
    reg_bus_if.host                             bus
);
    import tlk_reg_pkg::*;

    logic                  w_in_win;
    logic                  r_in_win;
    logic                  wen_q;
    logic [REG_OFS_W-1:0]  wofs_q;
    logic [REG_DATA_W-1:0] wdata_q;
    logic                  ren_q;
    logic [REG_OFS_W-1:0]  rofs_q;

    assign w_in_win = (i_reg_waddr & ~ADDR_MASK) == ADDR_BASE;
    assign r_in_win = (i_reg_raddr & ~ADDR_MASK) == ADDR_BASE;

    // strobes, out-of-window accesses are dropped here
    always_ff @(posedge clk) begin
        if (rst) begin
            wen_q   <= 1'b0;
            ren_q   <= 1'b0;
            bus.wen <= 1'b0;
            bus.ren <= 1'b0;
        end else begin
            wen_q   <= i_reg_wen & w_in_win;
            ren_q   <= i_reg_ren & r_in_win;
            bus.wen <= wen_q;
            bus.ren <= ren_q;
        end
    end

    // offsets keep only the bits under the mask
    always_ff @(posedge clk) begin
        wofs_q    <= REG_OFS_W'(i_reg_waddr & ADDR_MASK);
        wdata_q   <= i_reg_wdata;
        rofs_q    <= REG_OFS_W'(i_reg_raddr & ADDR_MASK);
        bus.wofs  <= wofs_q;
        bus.wdata <= wdata_q;
        bus.rofs  <= rofs_q;
    end

endmodule

//--- verilog/reg_cfg_file.sv
// TX and RX configuration registers, config-done pulses, soft reset timer and readback
module reg_cfg_file (
    input  logic                               clk,
    input  logic                               rst,
    reg_bus_if.target                          bus,
    output logic [tlk_reg_pkg::DMA_ADDR_W-1:0] o_tx_base_addr,
    output logic [31:0]                        o_tx_total_length,
    output logic [15:0]                        o_tx_packet_body,
    output logic [15:0]                        o_tx_packet_tail,
    output logic [15:0]                        o_tx_body_num,
    output logic [2:0]                         o_tx_mode,
    output logic                               o_loopback_ena,
    output logic                               o_tx_pre,
    output logic [tlk_reg_pkg::DMA_ADDR_W-1:0] o_rx_base_addr,
    output logic                               o_rx_fifo_rd,
    output logic                               o_tx_config_done,
    output logic                               o_rx_config_done,
    output logic                               o_soft_rst,
    output logic [tlk_reg_pkg::REG_DATA_W-1:0] o_cfg_rdata,
    output logic                               o_cfg_hit
);
    import tlk_reg_pkg::*;

    localparam int RST_CNT_W = $clog2(SOFT_RST_CYCLES);

    logic [REG_DATA_W-1:0] tx_addr_q;
    logic [REG_DATA_W-1:0] tx_len_q;
    logic [REG_DATA_W-1:0] tx_pkt_q;
    logic [REG_DATA_W-1:0] rx_addr_q;
    logic [REG_DATA_W-1:0] rx_ctrl_q;
    logic [RST_CNT_W-1:0]  rst_cnt;

    ////////////////////////////////////////
    // register writes and done pulses
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_addr_q        <= '0;
            tx_len_q         <= '0;
            tx_pkt_q         <= '0;
            rx_addr_q        <= '0;
            rx_ctrl_q        <= '0;
            o_tx_config_done <= 1'b0;
            o_rx_config_done <= 1'b0;
        end else begin
            // data of a config-done write is ignored
            o_tx_config_done <= bus.wen && bus.wofs == TX_CFG_OFS;
            o_rx_config_done <= bus.wen && bus.wofs == RX_CFG_OFS;
            if (bus.wen) begin
                case (bus.wofs)
                    TX_ADDR_OFS:   tx_addr_q <= bus.wdata;
                    TX_LENGTH_OFS: tx_len_q  <= bus.wdata;
                    TX_PACKET_OFS: tx_pkt_q  <= bus.wdata;
                    RX_ADDR_OFS:   rx_addr_q <= bus.wdata;
                    RX_CTRL_OFS:   rx_ctrl_q <= bus.wdata;
                    default: ;
                endcase
            end
        end
    end

    // soft reset, a new write restarts the count
    always_ff @(posedge clk) begin
        if (rst) begin
            o_soft_rst <= 1'b0;
            rst_cnt    <= '0;
        end else if (bus.wen && bus.wofs == SOFT_RST_OFS) begin
            o_soft_rst <= 1'b1;
            rst_cnt    <= RST_CNT_W'(SOFT_RST_CYCLES - 1);
        end else if (o_soft_rst) begin
            if (rst_cnt == '0) begin
                o_soft_rst <= 1'b0;
            end else begin
                rst_cnt <= rst_cnt - 1'b1;
            end
        end
    end

    // field decode
    assign o_tx_base_addr    = tx_addr_q[DMA_ADDR_W-1:0];
    assign o_tx_total_length = tx_len_q[31:0];
    assign o_tx_packet_body  = tx_pkt_q[15:0];
    assign o_tx_body_num     = tx_pkt_q[31:16];
    assign o_tx_packet_tail  = tx_pkt_q[47:32];
    assign o_tx_pre          = tx_pkt_q[59];
    assign o_tx_mode         = tx_pkt_q[62:60];
    assign o_loopback_ena    = tx_pkt_q[63];
    assign o_rx_base_addr    = rx_addr_q[DMA_ADDR_W-1:0];
    assign o_rx_fifo_rd      = rx_ctrl_q[0];

    // readback of configuration words
    always_comb begin
        o_cfg_hit   = 1'b1;
        o_cfg_rdata = '0;
        case (bus.rofs)
            TX_ADDR_OFS:   o_cfg_rdata = tx_addr_q;
            TX_LENGTH_OFS: o_cfg_rdata = tx_len_q;
            TX_PACKET_OFS: o_cfg_rdata = tx_pkt_q;
            RX_ADDR_OFS:   o_cfg_rdata = rx_addr_q;
            RX_CTRL_OFS:   o_cfg_rdata = rx_ctrl_q;
            default:       o_cfg_hit   = 1'b0;
        endcase
    end

endmodule

//--- verilog/irq_report.sv
// interrupt report word, loaded on TX, RX and link loss events with RX first
module irq_report (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_tx_interrupt,
    input  logic                   i_rx_interrupt,
    input  logic                   i_loss_interrupt,
    input  logic [15:0]            i_rx_frame_length,
    input  logic [15:0]            i_rx_frame_num,
    input  logic [7:0]             i_rx_data_type,
    input  logic                   i_rx_file_end_flag,
    input  logic                   i_rx_checksum_flag,
    input  logic [5:0]             i_rx_status,
    input  logic                   i_sync_loss,
    input  logic                   i_link_loss,
    output tlk_reg_pkg::irq_word_u o_irq_word
);
    import tlk_reg_pkg::*;

    irq_word_u irq_next;

    // word holds until the next event
    always_comb begin
        irq_next = o_irq_word;
        if (i_rx_interrupt) begin
            irq_next              = '0;
            irq_next.rx.kind      = IRQ_KIND_RX;
            irq_next.rx.data_type = i_rx_data_type;
            irq_next.rx.file_end  = i_rx_file_end_flag;
            irq_next.rx.checksum  = i_rx_checksum_flag;
            irq_next.rx.frame_num = i_rx_frame_num;
            irq_next.rx.frame_len = i_rx_frame_length;
        end else if (i_tx_interrupt) begin
            irq_next              = '0;
            irq_next.tx.kind      = IRQ_KIND_TX;
            irq_next.tx.done_mark = TX_DONE_MARK;
        end else if (i_loss_interrupt) begin
            irq_next                = '0;
            irq_next.loss.kind      = IRQ_KIND_LOSS;
            irq_next.loss.rx_status = i_rx_status;
            irq_next.loss.sync_loss = i_sync_loss;
            irq_next.loss.link_loss = i_link_loss;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_irq_word <= '0;
        end else begin
            o_irq_word <= irq_next;
        end
    end

endmodule

//--- verilog/reg_read_mux.sv
// read data select for configuration, status and interrupt words, two register stages
module reg_read_mux (
    input  logic                               clk,
    input  logic                               rst,
    reg_bus_if.target                          bus,
    input  logic [tlk_reg_pkg::REG_DATA_W-1:0] i_cfg_rdata,
    input  logic                               i_cfg_hit,
    input  tlk_reg_pkg::irq_word_u             i_irq_word,
    input  logic [9:0]                         i_tx_status,
    input  logic [5:0]                         i_rx_status,
    output logic [tlk_reg_pkg::REG_DATA_W-1:0] o_reg_rdata
);
    import tlk_reg_pkg::*;

    logic [REG_DATA_W-1:0] sel_data;
    logic [REG_DATA_W-1:0] rdata_q;

    always_comb begin
        sel_data = '0;
        if (i_cfg_hit) begin
            sel_data = i_cfg_rdata;
        end else begin
            case (bus.rofs)
                TX_STATUS_OFS: sel_data = {TX_STATUS_TAG, {(REG_DATA_W-14){1'b0}}, i_tx_status};
                RX_STATUS_OFS: sel_data = {RX_STATUS_TAG, {(REG_DATA_W-10){1'b0}}, i_rx_status};
                IRQ_OFS:       sel_data = i_irq_word;
                // unmapped offsets read as zero
                default:       sel_data = '0;
            endcase
        end
    end

    ////////////////////////////////////////
    // output pipeline, zero without a read
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata_q     <= '0;
            o_reg_rdata <= '0;
        end else begin
            rdata_q     <= bus.ren ? sel_data : '0;
            o_reg_rdata <= rdata_q;
        end
    end

endmodule

//--- verilog/tlk_reg_mgt.sv
// TLK2711 register management top, host access, configuration, interrupt report and readback
module tlk_reg_mgt (
    input  logic                                clk,
    input  logic                                rst,
    // host access
    input  logic                                i_reg_wen,
    input  logic [tlk_reg_pkg::HOST_ADDR_W-1:0] i_reg_waddr,
    input  logic [tlk_reg_pkg::REG_DATA_W-1:0]  i_reg_wdata,
    input  logic                                i_reg_ren,
    input  logic [tlk_reg_pkg::HOST_ADDR_W-1:0] i_reg_raddr,
    output logic [tlk_reg_pkg::REG_DATA_W-1:0]  o_reg_rdata,
    // events and status
    input  logic                                i_tx_interrupt,
    input  logic                                i_rx_interrupt,
    input  logic                                i_loss_interrupt,
    input  logic [15:0]                         i_rx_frame_length,
    input  logic [15:0]                         i_rx_frame_num,
    input  logic [7:0]                          i_rx_data_type,
    input  logic                                i_rx_file_end_flag,
    input  logic                                i_rx_checksum_flag,
    input  logic [5:0]                          i_rx_status,
    input  logic [9:0]                          i_tx_status,
    input  logic                                i_sync_loss,
    input  logic                                i_link_loss,
    output logic                                o_tx_irq,
    output logic                                o_rx_irq,
    output logic                                o_loss_irq,
    // transfer configuration
    output logic [tlk_reg_pkg::DMA_ADDR_W-1:0]  o_tx_base_addr,
    output logic [31:0]                         o_tx_total_length,
    output logic [15:0]                         o_tx_packet_body,
    output logic [15:0]                         o_tx_packet_tail,
    output logic [15:0]                         o_tx_body_num,
    output logic [2:0]                          o_tx_mode,
    output logic                                o_loopback_ena,
    output logic                                o_tx_pre,
    output logic [tlk_reg_pkg::DMA_ADDR_W-1:0]  o_rx_base_addr,
    output logic                                o_rx_fifo_rd,
    output logic                                o_tx_config_done,
    output logic                                o_rx_config_done,
    output logic                                o_soft_rst
);
    import tlk_reg_pkg::*;

    logic [REG_DATA_W-1:0] cfg_rdata;
    logic                  cfg_hit;
    irq_word_u             irq_word;

    reg_bus_if reg_bus ();

    reg_host_port u_host_port (
        .clk         (clk),
        .rst         (rst),
        .i_reg_wen   (i_reg_wen),
        .i_reg_waddr (i_reg_waddr),
        .i_reg_wdata (i_reg_wdata),
        .i_reg_ren   (i_reg_ren),
        .i_reg_raddr (i_reg_raddr),
        .bus         (reg_bus.host)
    );

    reg_cfg_file u_cfg_file (
        .clk               (clk),
        .rst               (rst),
        .bus               (reg_bus.target),
        .o_tx_base_addr    (o_tx_base_addr),
        .o_tx_total_length (o_tx_total_length),
        .o_tx_packet_body  (o_tx_packet_body),
        .o_tx_packet_tail  (o_tx_packet_tail),
        .o_tx_body_num     (o_tx_body_num),
        .o_tx_mode         (o_tx_mode),
        .o_loopback_ena    (o_loopback_ena),
        .o_tx_pre          (o_tx_pre),
        .o_rx_base_addr    (o_rx_base_addr),
        .o_rx_fifo_rd      (o_rx_fifo_rd),
        .o_tx_config_done  (o_tx_config_done),
        .o_rx_config_done  (o_rx_config_done),
        .o_soft_rst        (o_soft_rst),
        .o_cfg_rdata       (cfg_rdata),
        .o_cfg_hit         (cfg_hit)
    );

    irq_report u_irq_report (
        .clk                (clk),
        .rst                (rst),
        .i_tx_interrupt     (i_tx_interrupt),
        .i_rx_interrupt     (i_rx_interrupt),
        .i_loss_interrupt   (i_loss_interrupt),
        .i_rx_frame_length  (i_rx_frame_length),
        .i_rx_frame_num     (i_rx_frame_num),
        .i_rx_data_type     (i_rx_data_type),
        .i_rx_file_end_flag (i_rx_file_end_flag),
        .i_rx_checksum_flag (i_rx_checksum_flag),
        .i_rx_status        (i_rx_status),
        .i_sync_loss        (i_sync_loss),
        .i_link_loss        (i_link_loss),
        .o_irq_word         (irq_word)
    );

    reg_read_mux u_read_mux (
        .clk         (clk),
        .rst         (rst),
        .bus         (reg_bus.target),
        .i_cfg_rdata (cfg_rdata),
        .i_cfg_hit   (cfg_hit),
        .i_irq_word  (irq_word),
        .i_tx_status (i_tx_status),
        .i_rx_status (i_rx_status),
        .o_reg_rdata (o_reg_rdata)
    );

    // interrupt lines go straight to the processor
    assign o_tx_irq   = i_tx_interrupt;
    assign o_rx_irq   = i_rx_interrupt;
    assign o_loss_irq = i_loss_interrupt;

endmodule

//--- tb/tlk_reg_mgt_tb.sv
// directed testbench for the TLK2711 register block that runs with the file list in the project root
module tlk_reg_mgt_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import tlk_reg_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 8;
    // rough cycle budget per test where the soft reset dominates
    localparam int TEST_CYCLES = RST_CYCLES + 60 + 90 + 50 + 40 + 80 + 330;
    localparam int MARGIN_CYCLES = 200;

    logic clk;
    logic rst;
    logic i_reg_wen;
    logic [15:0] i_reg_waddr;
    logic [63:0] i_reg_wdata;
    logic i_reg_ren;
    logic [15:0] i_reg_raddr;
    logic [63:0] o_reg_rdata;
    logic i_tx_interrupt;
    logic i_rx_interrupt;
    logic i_loss_interrupt;
    logic [15:0] i_rx_frame_length;
    logic [15:0] i_rx_frame_num;
    logic [7:0] i_rx_data_type;
    logic i_rx_file_end_flag;
    logic i_rx_checksum_flag;
    logic [5:0] i_rx_status;
    logic [9:0] i_tx_status;
    logic i_sync_loss;
    logic i_link_loss;
    logic o_tx_irq;
    logic o_rx_irq;
    logic o_loss_irq;
    logic [31:0] o_tx_base_addr;
    logic [31:0] o_tx_total_length;
    logic [15:0] o_tx_packet_body;
    logic [15:0] o_tx_packet_tail;
    logic [15:0] o_tx_body_num;
    logic [2:0] o_tx_mode;
    logic o_loopback_ena;
    logic o_tx_pre;
    logic [31:0] o_rx_base_addr;
    logic o_rx_fifo_rd;
    logic o_tx_config_done;
    logic o_rx_config_done;
    logic o_soft_rst;

    integer seed = 4;
    int errors = 0;
    // expected words in the order TX addr, TX length, TX packet, RX addr and RX ctrl
    logic [7:0] cfg_ofs [5];
    logic [63:0] cfg_exp [5];

    tlk_reg_mgt UUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [63:0] data);
        @(negedge clk);
        i_reg_wen = 1'b1;
        i_reg_waddr = addr;
        i_reg_wdata = data;
        @(posedge clk);
        @(negedge clk);
        i_reg_wen = 1'b0;
    endtask

    // read word is on o_reg_rdata in cycle 4 counted from the sampling edge
    task automatic read_reg(input logic [15:0] addr, output logic [63:0] data);
        @(negedge clk);
        i_reg_ren = 1'b1;
        i_reg_raddr = addr;
        @(posedge clk);
        @(negedge clk);
        i_reg_ren = 1'b0;
        repeat (3) @(negedge clk);
        data = o_reg_rdata;
    endtask

    task automatic read_check(input string name, input logic [15:0] addr, input logic [63:0] exp);
        logic [63:0] data;
        read_reg(addr, data);
        check(name, data, exp);
    endtask

    task automatic check_fields();
        check("o_tx_base_addr", o_tx_base_addr, cfg_exp[0][31:0]);
        check("o_tx_total_length", o_tx_total_length, cfg_exp[1][31:0]);
        check("o_tx_packet_body", o_tx_packet_body, cfg_exp[2][15:0]);
        check("o_tx_body_num", o_tx_body_num, cfg_exp[2][31:16]);
        check("o_tx_packet_tail", o_tx_packet_tail, cfg_exp[2][47:32]);
        check("o_tx_pre", o_tx_pre, cfg_exp[2][59]);
        check("o_tx_mode", o_tx_mode, cfg_exp[2][62:60]);
        check("o_loopback_ena", o_loopback_ena, cfg_exp[2][63]);
        check("o_rx_base_addr", o_rx_base_addr, cfg_exp[3][31:0]);
        check("o_rx_fifo_rd", o_rx_fifo_rd, cfg_exp[4][0]);
    endtask

    // samples cycles 1 to 4 of a write and expects the pulse only on cycle 3
    task automatic check_pulse(input logic [15:0] addr, input logic tx_exp, input logic rx_exp);
        write_reg(addr, {$random(seed), $random(seed)});
        for (int c = 1; c <= 4; c++) begin
            check("o_tx_config_done", o_tx_config_done, (c == 3) ? tx_exp : 1'b0);
            check("o_rx_config_done", o_rx_config_done, (c == 3) ? rx_exp : 1'b0);
            @(negedge clk);
        end
    endtask

    task automatic fire_events(input logic tx, input logic rx, input logic loss);
        @(negedge clk);
        i_tx_interrupt = tx;
        i_rx_interrupt = rx;
        i_loss_interrupt = loss;
        @(posedge clk);
        check("o_tx_irq", o_tx_irq, tx);
        check("o_rx_irq", o_rx_irq, rx);
        check("o_loss_irq", o_loss_irq, loss);
        @(negedge clk);
        i_tx_interrupt = 1'b0;
        i_rx_interrupt = 1'b0;
        i_loss_interrupt = 1'b0;
    endtask

    task automatic shuffle_side_data();
        i_rx_frame_length = $random(seed);
        i_rx_frame_num = $random(seed);
        i_rx_data_type = $random(seed);
        i_rx_file_end_flag = $random(seed);
        i_rx_checksum_flag = $random(seed);
        i_rx_status = $random(seed);
        i_sync_loss = $random(seed);
        i_link_loss = $random(seed);
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////
    task automatic test_reset_state();
        check("o_tx_config_done", o_tx_config_done, 1'b0);
        check("o_rx_config_done", o_rx_config_done, 1'b0);
        check("o_soft_rst", o_soft_rst, 1'b0);
        read_check("o_reg_rdata", {8'h00, IRQ_OFS}, '0);
        for (int i = 0; i < 5; i++) begin
            read_check("o_reg_rdata", {8'h00, cfg_ofs[i]}, '0);
        end
    endtask

    task automatic test_cfg_write_read();
        for (int i = 0; i < 5; i++) begin
            cfg_exp[i] = {$random(seed), $random(seed)};
            write_reg({8'h00, cfg_ofs[i]}, cfg_exp[i]);
        end
        repeat (2) @(negedge clk);
        check_fields();
        for (int i = 0; i < 5; i++) begin
            read_check("o_reg_rdata", {8'h00, cfg_ofs[i]}, cfg_exp[i]);
        end
    endtask

    task automatic test_config_done();
        check_pulse({8'h00, TX_CFG_OFS}, 1'b1, 1'b0);
        check_pulse({8'h00, RX_CFG_OFS}, 1'b0, 1'b1);
        // base 0100 lies outside the window
        check_pulse({8'h01, TX_CFG_OFS}, 1'b0, 1'b0);
        write_reg({8'h01, TX_PACKET_OFS}, ~cfg_exp[2]);
        repeat (3) @(negedge clk);
        check_fields();
        read_check("o_reg_rdata", {8'h00, TX_PACKET_OFS}, cfg_exp[2]);
    endtask

    task automatic test_status_read();
        i_tx_status = $random(seed);
        i_rx_status = $random(seed);
        read_check("o_reg_rdata", {8'h00, TX_STATUS_OFS}, {4'h9, 50'h0, i_tx_status});
        read_check("o_reg_rdata", {8'h00, RX_STATUS_OFS}, {4'hA, 54'h0, i_rx_status});
        // the cycle after a read word carries no read
        @(negedge clk);
        check("o_reg_rdata", o_reg_rdata, '0);
        read_check("o_reg_rdata", 16'h0078, '0);
        read_check("o_reg_rdata", {8'h02, TX_ADDR_OFS}, '0);
    endtask

    task automatic test_irq_report();
        logic [63:0] rx_word;
        logic [63:0] tx_word;
        logic [63:0] loss_word;
        tx_word = {4'h1, 44'h0, 16'h5AA5};
        for (int k = 0; k < 6; k++) begin
            shuffle_side_data();
            rx_word = {4'h2, 18'h0, i_rx_data_type, i_rx_file_end_flag, i_rx_checksum_flag,
                       i_rx_frame_num, i_rx_frame_length};
            loss_word = {4'h3, 52'h0, i_rx_status, i_sync_loss, i_link_loss};
            case (k)
                0: begin
                    fire_events(0, 1, 0);
                    read_check("irq_word", 16'h0060, rx_word);
                end
                1: begin
                    fire_events(1, 0, 0);
                    read_check("irq_word", 16'h0060, tx_word);
                end
                2: begin
                    fire_events(0, 0, 1);
                    read_check("irq_word", 16'h0060, loss_word);
                end
                3: begin
                    fire_events(1, 1, 1);
                    read_check("irq_word", 16'h0060, rx_word);
                end
                4: begin
                    fire_events(1, 0, 1);
                    read_check("irq_word", 16'h0060, tx_word);
                end
                // the word holds without an event
                default: begin
                    read_check("irq_word", 16'h0060, tx_word);
                end
            endcase
        end
    endtask

    task automatic test_soft_reset();
        int rise_cycle;
        int high_cycles;
        // write_reg returns in cycle 1 of the write
        rise_cycle = 1;
        high_cycles = 0;
        write_reg({8'h00, SOFT_RST_OFS}, '0);
        while (!o_soft_rst && rise_cycle < 10) begin
            @(negedge clk);
            rise_cycle++;
        end
        check("soft_rst_rise_cycle", rise_cycle, 3);
        while (o_soft_rst && high_cycles < 400) begin
            high_cycles++;
            @(negedge clk);
        end
        if (high_cycles >= 400) begin
            $display("soft reset output did not fall within 400 cycles");
            errors++;
        end
        check("soft_rst_high_cycles", high_cycles, 256);
        check_fields();
        for (int i = 0; i < 5; i++) begin
            read_check("o_reg_rdata", {8'h00, cfg_ofs[i]}, cfg_exp[i]);
        end
    endtask

    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish in time");
        $display("Test failed");
        $finish;
    end

    initial begin
        cfg_ofs = '{TX_ADDR_OFS, TX_LENGTH_OFS, TX_PACKET_OFS, RX_ADDR_OFS, RX_CTRL_OFS};
        cfg_exp = '{default: '0};
        clk = 1'b0;
        rst = 1'b1;
        i_reg_wen = 1'b0;
        i_reg_waddr = '0;
        i_reg_wdata = '0;
        i_reg_ren = 1'b0;
        i_reg_raddr = '0;
        i_tx_interrupt = 1'b0;
        i_rx_interrupt = 1'b0;
        i_loss_interrupt = 1'b0;
        i_tx_status = '0;
        shuffle_side_data();
        i_rx_status = '0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset_state();
        test_cfg_write_read();
        test_config_done();
        test_status_read();
        test_irq_report();
        test_soft_reset();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- tlk_reg_mgt.f
verilog/tlk_reg_pkg.sv
verilog/reg_bus_if.sv
verilog/reg_host_port.sv
verilog/reg_cfg_file.sv
verilog/irq_report.sv
verilog/reg_read_mux.sv
verilog/tlk_reg_mgt.sv
tb/tlk_reg_mgt_tb.sv

//--- Bender.yml
package:
  name: tlk_reg_mgt

sources:
  - verilog/tlk_reg_pkg.sv
  - verilog/reg_bus_if.sv
  - verilog/reg_host_port.sv
  - verilog/reg_cfg_file.sv
  - verilog/irq_report.sv
  - verilog/reg_read_mux.sv
  - verilog/tlk_reg_mgt.sv
  - target: test
    files:
      - tb/tlk_reg_mgt_tb.sv
